// File: Bender.yml
package:
  name: cpu_back_end

sources:
  - target: any(rtl, test)
    files:
      - verilog/cpuPkg.sv
      - verilog/stageReg.sv
      - verilog/memStage.sv
      - verilog/mem2Stage.sv
      - verilog/wbStage.sv
      - verilog/regFile.sv
      - verilog/cpuBackEnd.sv

  - target: test
    files:
      - testbench/cpuBackEnd_props.sv
      - testbench/cpuBackEnd_tb.sv

// File: testbench/cpuBackEnd_props.sv
// back-end assertions on register write gating and stalled data memory writes, with bind
`timescale 1ns/100ps
`default_nettype none

module cpuBackEnd_props (
    input logic        clk,
    input logic        rst,
    input logic        stall,
    input logic        exValid,
    input logic [31:0] heldWord,
    input logic        wbWrite,
    input logic [4:0]  wbDst
);

    int   assertFails = 0;
    logic seenValid;                                   // valid input seen since reset

    always_ff @(posedge clk) begin
        if (rst) begin
            seenValid <= 1'b0;
        end else if (exValid) begin
            seenValid <= 1'b1;
        end
    end

    noZeroWrite: assert property (@(posedge clk) disable iff (rst) wbWrite |-> wbDst != 5'd0)
        else begin
            $error("register write raised for register zero");
            assertFails++;
        end

    // the word addressed by a held store keeps its contents
    noStallStore: assert property (@(posedge clk) disable iff (rst)
        stall |=> heldWord === $past(heldWord))
        else begin
            $error("data memory written while stalled");
            assertFails++;
        end

    quietAfterReset: assert property (@(posedge clk) disable iff (rst) !seenValid |-> !wbWrite)
        else begin
            $error("wbWrite high before any valid instruction entered the back end");
            assertFails++;
        end

endmodule

bind cpuBackEnd cpuBackEnd_props uProps (
    .clk      (clk),
    .rst      (rst),
    .stall    (stall),
    .exValid  (exIn.valid),
    .heldWord (uMem.mem[uMem.wordAddr]),
    .wbWrite  (wbWrite),
    .wbDst    (wbDst)
);

`default_nettype wire

// File: testbench/cpuBackEnd_tb.sv
// back-end testbench: clock and reset, stimulus table, memory and register models, checks
`timescale 1ns/100ps
`default_nettype none

module cpuBackEnd_tb
    import cpuPkg::*;
();

    // one row is one cycle of front-end output
    typedef struct packed {
        logic [2:0]  testId;
        ExMemBus     ex;
        logic        stall;
        logic        flush;
        logic        disWr;
        logic [31:0] expVal;                           // expected wb value unless a load
    } StepType;

    typedef struct packed {
        logic        valid;
        logic        regWr;
        logic [4:0]  dst;
        logic [31:0] val;
    } WbSlot;

    logic        clk;
    logic        rst;
    logic        stall;
    logic        flush;
    logic        disWr;
    ExMemBus     exIn;
    logic [4:0]  rdAddrA;
    logic [4:0]  rdAddrB;
    logic [31:0] rdDataA;
    logic [31:0] rdDataB;
    logic [31:0] wbResult;
    logic [4:0]  wbDst;
    logic        wbWrite;

    StepType     stepTable [$];
    StepType     applied;                              // inputs in effect since the last edge
    StepType     s1;                                   // model of the ex/mem register
    WbSlot       s2;
    WbSlot       s3;                                   // instruction in writeback
    logic [31:0] memModel [DMEM_WORDS];
    logic [31:0] regModel [32];
    integer      seed;
    int          testErrs;
    int          errCount;
    int          testsFailed;
    string       testNames [5] = '{"alu and move", "link", "store and load", "flush",
                                   "stall and write disable"};

    cpuBackEnd DUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic addOp(input int id, input MemOpType op, input WbSelType sel,
                         input logic [4:0] dst, input logic [31:0] pc, input logic [31:0] alu,
                         input logic [31:0] b, input logic [31:0] expVal);
        StepType st;
        st = '0;
        st.testId = id[2:0];
        st.ex = {1'b1, pc, alu, b, dst, sel, !(op inside {MEM_SB, MEM_SH, MEM_SW}), op};
        st.expVal = expVal;
        stepTable.push_back(st);
    endtask

    task automatic addIdle(input int id, input logic st, input logic fl, input logic dw);
        StepType s;
        s = '0;                                        // bubble with valid low
        s.testId = id[2:0];
        s.stall = st;
        s.flush = fl;
        s.disWr = dw;
        stepTable.push_back(s);
    endtask

    task automatic buildTable();
        addOp(0, MEM_NONE, WB_ALU, 5'd3, 32'h100, 32'h12345678, 32'h0, 32'h12345678);
        addOp(0, MEM_NONE, WB_OUTB, 5'd4, 32'h104, 32'h0, 32'hcafef00d, 32'hcafef00d);
        addOp(0, MEM_NONE, WB_ALU, 5'd0, 32'h108, 32'hffffffff, 32'h0, 32'hffffffff);
        addOp(0, MEM_NONE, WB_OUTB, 5'd31, 32'h10c, 32'h0, 32'h0000beef, 32'h0000beef);
        addOp(1, MEM_NONE, WB_PCPLUS8, 5'd31, 32'h00400100, 32'h0, 32'h0, 32'h00400108);
        addOp(1, MEM_NONE, WB_PCPLUS8, 5'd5, 32'hfffffffc, 32'h0, 32'h0, 32'h00000004);
        // random words, partial overwrites, then every load width over the same bytes
        addOp(2, MEM_SW, WB_ALU, 5'd0, 32'h200, 32'h40, $random(seed), 32'h0);
        addOp(2, MEM_SW, WB_ALU, 5'd0, 32'h204, 32'h44, $random(seed), 32'h0);
        addOp(2, MEM_SH, WB_ALU, 5'd0, 32'h208, 32'h46, $random(seed), 32'h0);
        addOp(2, MEM_SB, WB_ALU, 5'd0, 32'h20c, 32'h41, $random(seed), 32'h0);
        addOp(2, MEM_LW, WB_DMOUT, 5'd6, 32'h210, 32'h40, 32'h0, 32'h0);
        addOp(2, MEM_LH, WB_DMOUT, 5'd7, 32'h214, 32'h42, 32'h0, 32'h0);
        addOp(2, MEM_LHU, WB_DMOUT, 5'd8, 32'h218, 32'h46, 32'h0, 32'h0);
        addOp(2, MEM_LB, WB_DMOUT, 5'd9, 32'h21c, 32'h41, 32'h0, 32'h0);
        addOp(2, MEM_LBU, WB_DMOUT, 5'd10, 32'h220, 32'h43, 32'h0, 32'h0);
        addOp(2, MEM_LB, WB_DMOUT, 5'd11, 32'h224, 32'h47, 32'h0, 32'h0);
        addOp(2, MEM_LW, WB_DMOUT, 5'd12, 32'h228, 32'h44, 32'h0, 32'h0);
        // second write to r14 is flushed on its way into writeback
        addOp(3, MEM_NONE, WB_ALU, 5'd14, 32'h300, 32'haaaa5555, 32'h0, 32'haaaa5555);
        addOp(3, MEM_NONE, WB_ALU, 5'd14, 32'h304, 32'h11111111, 32'h0, 32'h11111111);
        addIdle(3, 1'b0, 1'b0, 1'b0);
        addIdle(3, 1'b0, 1'b1, 1'b0);
        addOp(4, MEM_NONE, WB_ALU, 5'd19, 32'h400, 32'h19191919, 32'h0, 32'h19191919);
        addIdle(4, 1'b0, 1'b0, 1'b0);
        addOp(4, MEM_SW, WB_ALU, 5'd0, 32'h408, 32'h80, $random(seed), 32'h0);
        addIdle(4, 1'b1, 1'b0, 1'b0);                   // store held in the mem stage
        addIdle(4, 1'b1, 1'b0, 1'b0);
        addIdle(4, 1'b1, 1'b0, 1'b0);
        addOp(4, MEM_LW, WB_DMOUT, 5'd16, 32'h40c, 32'h80, 32'h0, 32'h0);
        addOp(4, MEM_NONE, WB_ALU, 5'd17, 32'h410, 32'h17171717, 32'h0, 32'h17171717);
        addOp(4, MEM_NONE, WB_ALU, 5'd18, 32'h414, 32'h18181818, 32'h0, 32'h18181818);
        addIdle(4, 1'b0, 1'b0, 1'b0);
        addIdle(4, 1'b1, 1'b0, 1'b1);                   // r17 held in wb with its write masked
        addIdle(4, 1'b0, 1'b0, 1'b0);
        addIdle(4, 1'b0, 1'b0, 1'b1);                   // r18 is never written
    endtask

    // memory access as the instruction leaves the mem stage
    task automatic memAccess(input StepType st, output WbSlot ws);
        logic [DMEM_AW-1:0] wa;
        logic [1:0]         off;
        logic [31:0]        word;
        logic [7:0]         lb;
        logic [15:0]        lh;
        logic [31:0]        ld;
        wa   = st.ex.aluOut[DMEM_AW+1:2];
        off  = st.ex.aluOut[1:0];
        word = memModel[wa];
        lb   = word[8*off +: 8];
        lh   = off[1] ? word[31:16] : word[15:0];
        case (st.ex.memOp)
            MEM_LB:  ld = {{24{lb[7]}}, lb};
            MEM_LBU: ld = {24'b0, lb};
            MEM_LH:  ld = {{16{lh[15]}}, lh};
            MEM_LHU: ld = {16'b0, lh};
            default: ld = word;
        endcase
        if (st.ex.valid) begin
            case (st.ex.memOp)
                MEM_SW:  memModel[wa] = st.ex.outB;
                MEM_SH:  memModel[wa][16*off[1] +: 16] = st.ex.outB[15:0];
                MEM_SB:  memModel[wa][8*off +: 8] = st.ex.outB[7:0];
                default: ;
            endcase
        end
        ws.valid = st.ex.valid;
        ws.regWr = st.ex.regWr;
        ws.dst   = st.ex.dst;
        ws.val   = (st.ex.wbSel == WB_DMOUT) ? ld : st.expVal;
    endtask

    task automatic advanceModel();
        if (s3.valid && s3.regWr && s3.dst != 5'd0 && !applied.disWr) begin
            regModel[s3.dst] = s3.val;
        end
        if (!applied.stall) begin
            s3 = applied.flush ? '0 : s2;              // flush turns the wb entry into a bubble
            memAccess(s1, s2);
            s1 = applied;
        end
    endtask

    task automatic reportMismatch(input string sig, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("MISMATCH %s: got %h expected %h at %0t", sig, got, exp, $time);
        testErrs++;
    endtask

    task automatic checkOutputs();
        logic expWr;
        expWr = s3.valid && s3.regWr && s3.dst != 5'd0 && !applied.disWr;
        if (wbWrite !== expWr) reportMismatch("wbWrite", wbWrite, expWr);
        if (s3.valid && s3.regWr && wbResult !== s3.val) begin
            reportMismatch("wbResult", wbResult, s3.val);
        end
        if (s3.valid && s3.regWr && wbDst !== s3.dst) begin
            reportMismatch("wbDst", wbDst, s3.dst);
        end
    endtask

    task automatic applyStep(input StepType st, input logic [4:0] ra, input logic [4:0] rb);
        @(posedge clk);
        advanceModel();
        exIn    <= st.ex;
        stall   <= st.stall;
        flush   <= st.flush;
        disWr   <= st.disWr;
        rdAddrA <= ra;
        rdAddrB <= rb;
        applied = st;
        @(negedge clk);                                // outputs settled
        checkOutputs();
    endtask

    task automatic finishTest(input int id);
        int n;
        n = 0;
        while ((s1.ex.valid || s2.valid || s3.valid || wbWrite !== 1'b0) && n < 10) begin
            applyStep('0, 5'd0, 5'd0);
            n++;
        end
        if (s1.ex.valid || s2.valid || s3.valid || wbWrite !== 1'b0) begin
            $display("test %0d: writeback still active after %0d idle cycles", id, n);
            testErrs++;
        end
        for (int r = 0; r < 32; r++) begin
            applyStep('0, r[4:0], 5'(31 - r));
            if (rdDataA !== regModel[r]) reportMismatch("rdDataA", rdDataA, regModel[r]);
            if (rdDataB !== regModel[31 - r]) reportMismatch("rdDataB", rdDataB, regModel[31 - r]);
        end
        if (testErrs == 0) begin
            $display("test %0d %s: ok", id, testNames[id]);
        end else begin
            $display("test %0d %s: %0d errors", id, testNames[id], testErrs);
            testsFailed++;
        end
        errCount += testErrs;
        testErrs = 0;
    endtask

    initial begin
        seed        = 32'h954e896b;
        rst         = 1'b1;
        stall       = 1'b0;
        flush       = 1'b0;
        disWr       = 1'b0;
        exIn        = '0;
        rdAddrA     = 5'd0;
        rdAddrB     = 5'd0;
        applied     = '0;
        s1          = '0;
        s2          = '0;
        s3          = '0;
        testErrs    = 0;
        errCount    = 0;
        testsFailed = 0;
        for (int r = 0; r < 32; r++) regModel[r] = '0;
        buildTable();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (int t = 0; t < 5; t++) begin
            foreach (stepTable[i]) begin
                if (stepTable[i].testId == t) applyStep(stepTable[i], 5'd0, 5'd0);
            end
            finishTest(t);
        end
        errCount += DUT.uProps.assertFails;
        $display("tests 5, failed %0d, errors %0d, assertion failures %0d", testsFailed,
                 errCount, DUT.uProps.assertFails);
        if (errCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
verilog/cpuPkg.sv
verilog/stageReg.sv
verilog/memStage.sv
verilog/mem2Stage.sv
verilog/wbStage.sv
verilog/regFile.sv
verilog/cpuBackEnd.sv
testbench/cpuBackEnd_props.sv
testbench/cpuBackEnd_tb.sv

// File: verilog/cpuBackEnd.sv
// cpuBackEnd: memory, mem2 and writeback stages with register file
`timescale 1ns/100ps
`default_nettype none

module cpuBackEnd
    import cpuPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        stall,
    input  logic        flush,
    input  logic        disWr,
    input  ExMemBus     exIn,
    input  logic [4:0]  rdAddrA,
    input  logic [4:0]  rdAddrB,
    output logic [31:0] rdDataA,
    output logic [31:0] rdDataB,
    output logic [31:0] wbResult,
    output logic [4:0]  wbDst,
    output logic        wbWrite
);

    ExMemBus     memReq;
    MemM2Bus     memRsp;
    logic [31:0] rdWord;
    M2WbBus      m2Out;
    M2WbBus      wbReq;

    stageReg #(.T(ExMemBus)) uExMem (
        .clk   (clk),
        .rst   (rst),
        .stall (stall),
        .flush (1'b0),
        .d     (exIn),
        .q     (memReq)
    );

    memStage uMem (
        .clk    (clk),
        .rst    (rst),
        .stall  (stall),
        .memReq (memReq),
        .memRsp (memRsp),
        .rdWord (rdWord)
    );

    mem2Stage uMem2 (
        .memRsp (memRsp),
        .rdWord (rdWord),
        .m2Out  (m2Out)
    );

    stageReg #(.T(M2WbBus)) uM2Wb (
        .clk   (clk),
        .rst   (rst),
        .stall (stall),
        .flush (flush),                                // kills the instruction entering wb
        .d     (m2Out),
        .q     (wbReq)
    );

    wbStage uWb (
        .wbReq    (wbReq),
        .disWr    (disWr),
        .wbResult (wbResult),
        .wbDst    (wbDst),
        .wbWrite  (wbWrite)
    );

    regFile uRegs (
        .clk     (clk),
        .rst     (rst),
        .wrEn    (wbWrite),
        .wrAddr  (wbDst),
        .wrData  (wbResult),
        .rdAddrA (rdAddrA),
        .rdAddrB (rdAddrB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB)
    );

endmodule

`default_nettype wire

// File: verilog/cpuPkg.sv
// data memory sizing, writeback and memory-op encodings, back-end stage payloads
`default_nettype none

package cpuPkg;

    localparam int DMEM_WORDS = 256;                   // data memory depth in 32-bit words
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);    // word address width

    // writeback source, same order as the result mux inputs
    typedef enum logic [1:0] {
        WB_PCPLUS8 = 2'd0,                             // link value for jal/jalr
        WB_ALU     = 2'd1,
        WB_OUTB    = 2'd2,                             // move-to value
        WB_DMOUT   = 2'd3                              // aligned load data
    } WbSelType;

    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LB   = 4'd1,
        MEM_LBU  = 4'd2,
        MEM_LH   = 4'd3,
        MEM_LHU  = 4'd4,
        MEM_LW   = 4'd5,
        MEM_SB   = 4'd6,
        MEM_SH   = 4'd7,
        MEM_SW   = 4'd8
    } MemOpType;

    // executed instruction as handed over by the execute stage
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] aluOut;                           // effective address for loads/stores
        logic [31:0] outB;                             // store data or move-to value
        logic [4:0]  dst;
        WbSelType    wbSel;
        logic        regWr;
        MemOpType    memOp;
    } ExMemBus;

    // registered beside the read word, mem2 still needs memOp and addr[1:0]
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] aluOut;
        logic [31:0] outB;
        logic [4:0]  dst;
        WbSelType    wbSel;
        logic        regWr;
        MemOpType    memOp;
    } MemM2Bus;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] aluOut;
        logic [31:0] outB;
        logic [4:0]  dst;
        WbSelType    wbSel;
        logic        regWr;
        logic [31:0] dmOut;                            // extended load result
    } M2WbBus;

endpackage

`default_nettype wire

// File: verilog/mem2Stage.sv
// mem2Stage: load lane selection and sign or zero extension
`timescale 1ns/100ps
`default_nettype none

module mem2Stage
    import cpuPkg::*;
(
    input  MemM2Bus     memRsp,
    input  logic [31:0] rdWord,
    output M2WbBus      m2Out
);

    logic [7:0]  byteLane;
    logic [15:0] halfLane;
    logic [31:0] loadData;

    assign byteLane = rdWord[8*memRsp.aluOut[1:0] +: 8];
    assign halfLane = memRsp.aluOut[1] ? rdWord[31:16] : rdWord[15:0];   // addr[0] ignored

    always_comb begin
        case (memRsp.memOp)
            MEM_LB:  loadData = {{24{byteLane[7]}}, byteLane};
            MEM_LBU: loadData = {24'b0, byteLane};
            MEM_LH:  loadData = {{16{halfLane[15]}}, halfLane};
            MEM_LHU: loadData = {16'b0, halfLane};
            default: loadData = rdWord;                // lw, and don't care otherwise
        endcase
    end

    always_comb begin
        m2Out.valid  = memRsp.valid;
        m2Out.pc     = memRsp.pc;
        m2Out.aluOut = memRsp.aluOut;
        m2Out.outB   = memRsp.outB;
        m2Out.dst    = memRsp.dst;
        m2Out.wbSel  = memRsp.wbSel;
        m2Out.regWr  = memRsp.regWr;
        m2Out.dmOut  = loadData;
    end

endmodule

`default_nettype wire

// File: verilog/memStage.sv
// memStage: data memory with byte-enable stores, registered read word and payload register
`timescale 1ns/100ps
`default_nettype none

module memStage
    import cpuPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        stall,
    input  ExMemBus     memReq,
    output MemM2Bus     memRsp,
    output logic [31:0] rdWord
);

    logic [31:0]        mem [DMEM_WORDS];              // contents are not reset
    logic [DMEM_AW-1:0] wordAddr;
    logic [1:0]         byteOff;
    logic [3:0]         byteEn;
    logic [31:0]        stWord;                        // store data moved to its lanes
    logic               isStore;
    logic               wrStrobe;
    MemM2Bus            memNext;

    assign wordAddr = memReq.aluOut[DMEM_AW+1:2];
    assign byteOff  = memReq.aluOut[1:0];

    always_comb begin
        isStore = 1'b1;
        byteEn  = 4'b0000;
        stWord  = memReq.outB;
        case (memReq.memOp)
            MEM_SW: byteEn = 4'b1111;                  // byte offset ignored
            MEM_SH: begin
                byteEn = byteOff[1] ? 4'b1100 : 4'b0011;
                stWord = {2{memReq.outB[15:0]}};
            end
            MEM_SB: begin
                byteEn = 4'b0001 << byteOff;
                stWord = {4{memReq.outB[7:0]}};
            end
            default: isStore = 1'b0;
        endcase
    end

    // gated by stall so a held store is written only once
    assign wrStrobe = memReq.valid & isStore & ~stall;

    always_ff @(posedge clk) begin
        if (wrStrobe) begin
            for (int i = 0; i < 4; i++) begin
                if (byteEn[i]) mem[wordAddr][8*i +: 8] <= stWord[8*i +: 8];
            end
        end
        if (!stall) rdWord <= mem[wordAddr];           // read lines up with memRsp
    end

    always_comb begin
        memNext.valid  = memReq.valid;
        memNext.pc     = memReq.pc;
        memNext.aluOut = memReq.aluOut;
        memNext.outB   = memReq.outB;
        memNext.dst    = memReq.dst;
        memNext.wbSel  = memReq.wbSel;
        memNext.regWr  = memReq.regWr;
        memNext.memOp  = memReq.memOp;
    end

    stageReg #(.T(MemM2Bus)) uMemM2 (
        .clk   (clk),
        .rst   (rst),
        .stall (stall),
        .flush (1'b0),                                 // flushing happens at the wb boundary
        .d     (memNext),
        .q     (memRsp)
    );

endmodule

`default_nettype wire

// File: verilog/regFile.sv
// regFile: 32x32 register file, one write port, two read ports with write-first bypass
`timescale 1ns/100ps
`default_nettype none

module regFile (
    input  logic        clk,
    input  logic        rst,
    input  logic        wrEn,
    input  logic [4:0]  wrAddr,
    input  logic [31:0] wrData,
    input  logic [4:0]  rdAddrA,
    input  logic [4:0]  rdAddrB,
    output logic [31:0] rdDataA,
    output logic [31:0] rdDataB
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) regs[i] <= '0;
        end else if (wrEn && wrAddr != 5'd0) begin
            regs[wrAddr] <= wrData;                    // $0 never written
        end
    end

    always_comb begin
        if (rdAddrA == 5'd0)
            rdDataA = '0;
        else if (wrEn && wrAddr == rdAddrA)
            rdDataA = wrData;                          // same-cycle bypass
        else
            rdDataA = regs[rdAddrA];
    end

    always_comb begin
        if (rdAddrB == 5'd0)
            rdDataB = '0;
        else if (wrEn && wrAddr == rdAddrB)
            rdDataB = wrData;
        else
            rdDataB = regs[rdAddrB];
    end

endmodule

`default_nettype wire

// File: verilog/stageReg.sv
// stageReg: pipeline register for any payload type, with reset, flush and stall hold
`timescale 1ns/100ps
`default_nettype none

module stageReg #(
    parameter type T = logic [31:0]
) (
    input  logic clk,
    input  logic rst,
    input  logic stall,
    input  logic flush,
    input  T     d,
    output T     q
);

    // hold beats flush, reset beats both
    always_ff @(posedge clk) begin
        if (rst) begin
            q <= '0;
        end else if (stall) begin
            q <= q;                                    // keep the instruction in place
        end else if (flush) begin
            q <= '0;                                   // bubble, valid and regWr low
        end else begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// File: verilog/wbStage.sv
// wbStage: writeback result mux and register write gating
`timescale 1ns/100ps
`default_nettype none

module wbStage
    import cpuPkg::*;
(
    input  M2WbBus      wbReq,
    input  logic        disWr,
    output logic [31:0] wbResult,
    output logic [4:0]  wbDst,
    output logic        wbWrite
);

    always_comb begin
        case (wbReq.wbSel)
            WB_PCPLUS8: wbResult = wbReq.pc + 32'd8;   // return address past the delay slot
            WB_ALU:     wbResult = wbReq.aluOut;
            WB_OUTB:    wbResult = wbReq.outB;
            default:    wbResult = wbReq.dmOut;
        endcase
    end

    assign wbDst = wbReq.dst;

    // disWr only masks the current cycle, the instruction itself stays
    assign wbWrite = wbReq.valid & wbReq.regWr & (wbReq.dst != 5'd0) & ~disWr;

endmodule

`default_nettype wire
